//--- compile.f
source/exe_pkg.sv
source/exe_mem_if.sv
source/exe_unit.sv
source/exe_mem_reg.sv
source/mem_unit.sv
source/data_ram.sv
source/exe_mem_top.sv
tests/exe_mem_top_tb.sv

//--- Bender.yml
package:
  name: exe_mem_slice

sources:
  - files:
      - source/exe_pkg.sv
      - source/exe_mem_if.sv
      - source/exe_unit.sv
      - source/exe_mem_reg.sv
      - source/mem_unit.sv
      - source/data_ram.sv
      - source/exe_mem_top.sv
  - target: test
    files:
      - tests/exe_mem_top_tb.sv

//--- tests/exe_mem_top_tb.sv
/* directed testbench for the execute-to-memory slice; assumes RAM_WORDS at its
   default and word-aligned memory addresses */
`default_nettype none

module exe_mem_top_tb;

    import exe_pkg::*;

    localparam int RAM_WORDS = 256;
    localparam int WA = $clog2(RAM_WORDS);
    localparam int N_ALU = 18;
    localparam int N_MEM = 8;
    localparam int N_BP = 24;
    // reset, alu, store/load, back-pressure, redirect, ebreak, reset test
    localparam int MAX_CYCLES = 10 + N_ALU * 4 + N_MEM * 8 + N_BP * 16 + 60 + 40 + 30;

    typedef struct packed {
        logic [31:0]           pc;
        logic [GPR_ADDR_W-1:0] rd;
        logic                  write;
        logic [31:0]           data;
        logic [31:0]           cyc;
    } wb_rec_t;

    logic                  clk;
    logic                  reset;
    logic                  in_valid_i;
    logic                  in_ready_o;
    logic [31:0]           pc_i;
    alu_op_e               op_i;
    mem_op_e               mem_op_i;
    logic [31:0]           rs1_i;
    logic [31:0]           rs2_i;
    logic [31:0]           imm_i;
    logic [GPR_ADDR_W-1:0] rd_i;
    logic                  gpr_write_i;
    logic                  wb_valid_o;
    logic                  wb_ready_i;
    logic [31:0]           wb_pc_o;
    logic [GPR_ADDR_W-1:0] wb_rd_o;
    logic                  wb_write_o;
    logic [31:0]           wb_data_o;
    logic                  redirect_o;
    logic [31:0]           redirect_pc_o;
    logic                  halted_o;

    integer        seed = 70642;
    integer        ready_seed = 70642;
    integer        error_count = 0;
    integer        cycle_count = 0;
    logic [31:0]   next_pc = 32'h0000_1000;
    logic          strict_latency = 1'b0;
    logic          bp_enable = 1'b0;
    logic          saw_full = 1'b0;
    logic [31:0]   shadow [RAM_WORDS];
    wb_rec_t       exp_q[$];
    logic [31:0]   redir_q[$];
    logic [WA-1:0] stored_q[$];

    exe_mem_top exe_mem_top_i (
        .clk           (clk),
        .reset         (reset),
        .in_valid_i    (in_valid_i),
        .in_ready_o    (in_ready_o),
        .pc_i          (pc_i),
        .op_i          (op_i),
        .mem_op_i      (mem_op_i),
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .imm_i         (imm_i),
        .rd_i          (rd_i),
        .gpr_write_i   (gpr_write_i),
        .wb_valid_o    (wb_valid_o),
        .wb_ready_i    (wb_ready_i),
        .wb_pc_o       (wb_pc_o),
        .wb_rd_o       (wb_rd_o),
        .wb_write_o    (wb_write_o),
        .wb_data_o     (wb_data_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .halted_o      (halted_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        while (cycle_count < MAX_CYCLES) @(posedge clk);
        $display("timeout: run exceeded %0d cycles, errors: %0d", MAX_CYCLES, error_count);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // random writeback stalls
    initial begin
        integer r;
        forever begin
            @(posedge clk);
            #1;
            if (bp_enable) begin
                r = $random(ready_seed);
                wb_ready_i = r[0];
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Mismatch %s: got %h expected %h at cycle %0d", name, got, exp, cycle_count);
        error_count++;
    endtask

    task automatic flag_failure(input string msg);
        $display("error at cycle %0d: %s", cycle_count, msg);
        error_count++;
    endtask

    // records and redirect pulses, sampled mid-cycle
    always @(negedge clk) begin
        wb_rec_t     rec;
        logic [31:0] target;
        if (!reset) begin
            if (exp_q.size() == 2 && !wb_ready_i) begin
                if (in_ready_o)
                    flag_failure("in_ready_o high while both stages are full");
                else
                    saw_full = 1'b1;
            end
            if (wb_valid_o && wb_ready_i) begin
                if (exp_q.size() == 0) begin
                    flag_failure("writeback record with no bundle in flight");
                end else begin
                    rec = exp_q.pop_front();
                    if (wb_pc_o !== rec.pc)
                        report_mismatch("wb_pc_o", wb_pc_o, rec.pc);
                    if (wb_rd_o !== rec.rd)
                        report_mismatch("wb_rd_o", wb_rd_o, rec.rd);
                    if (wb_write_o !== rec.write)
                        report_mismatch("wb_write_o", wb_write_o, rec.write);
                    if (rec.write && wb_data_o !== rec.data)
                        report_mismatch("wb_data_o", wb_data_o, rec.data);
                    if (strict_latency && cycle_count != rec.cyc + 1)
                        report_mismatch("wb_valid_o cycle", cycle_count, rec.cyc + 1);
                end
            end
            if (redirect_o) begin
                if (in_ready_o)
                    flag_failure("in_ready_o high in the redirect cycle");
                if (redir_q.size() == 0) begin
                    flag_failure("redirect_o pulse with no taken branch or jump");
                end else begin
                    target = redir_q.pop_front();
                    if (redirect_pc_o !== target)
                        report_mismatch("redirect_pc_o", redirect_pc_o, target);
                end
            end
        end
    end

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [31:0] alu_model(input alu_op_e op, input logic [31:0] pc,
                                              input logic [31:0] a, input logic [31:0] b,
                                              input logic [31:0] imm);
        case (op)
            alu_add: return a + b;
            alu_sub: return a - b;
            alu_and: return a & b;
            alu_or:  return a | b;
            alu_xor: return a ^ b;
            alu_sll: return a << b[4:0];
            alu_srl: return a >> b[4:0];
            alu_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_imm: return imm;
            alu_jal: return pc + 32'd4;
            default: return 32'd0;
        endcase
    endfunction

    // drives one bundle, waits for acceptance and queues the expected record
    task automatic send(input alu_op_e op, input mem_op_e mop, input logic [31:0] rs1,
                        input logic [31:0] rs2, input logic [31:0] imm,
                        input logic [GPR_ADDR_W-1:0] rd, input logic wr);
        wb_rec_t     rec;
        logic [31:0] addr;
        logic        taken;
        addr = rs1 + imm;
        taken = (op == alu_beq && rs1 == rs2) || (op == alu_bne && rs1 != rs2)
                || op == alu_jal;
        rec.pc = next_pc;
        rec.rd = rd;
        rec.write = wr && mop != mem_store && op != alu_beq && op != alu_bne
                    && op != alu_ebreak;
        rec.data = alu_model(op, next_pc, rs1, rs2, imm);
        if (mop == mem_store) begin
            shadow[addr[WA+1:2]] = rs2;
            rec.data = addr;
        end else if (mop == mem_load) begin
            rec.data = shadow[addr[WA+1:2]];
        end
        in_valid_i = 1'b1;
        pc_i = next_pc;
        op_i = op;
        mem_op_i = mop;
        rs1_i = rs1;
        rs2_i = rs2;
        imm_i = imm;
        rd_i = rd;
        gpr_write_i = wr;
        @(negedge clk);
        while (!in_ready_o) @(negedge clk);
        @(posedge clk);
        #1;
        in_valid_i = 1'b0;
        rec.cyc = cycle_count;
        exp_q.push_back(rec);
        if (taken)
            redir_q.push_back(next_pc + imm);
        next_pc = taken ? next_pc + imm : next_pc + 32'd4;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || redir_q.size() != 0) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic store_word(input logic [WA-1:0] word, input logic [31:0] data);
        logic [31:0] base;
        base = rand_word();
        stored_q.push_back(word);
        send(alu_add, mem_store, base, data, {word, 2'b00} - base, rand_word(), 1'b1);
    endtask

    task automatic load_word(input logic [WA-1:0] word);
        logic [31:0] base;
        base = rand_word();
        send(alu_add, mem_load, base, rand_word(), {word, 2'b00} - base, rand_word(), 1'b1);
    endtask

    task automatic exercise_alu();
        strict_latency = 1'b1;
        for (int i = 0; i < N_ALU; i++) begin
            send(alu_op_e'(i % 9), mem_none, rand_word(), rand_word(), rand_word(),
                 rand_word(), 1'b1);
        end
        wait_drain();
        strict_latency = 1'b0;
    endtask

    task automatic store_then_load();
        for (int i = 0; i < N_MEM; i++) begin
            store_word(rand_word(), rand_word());
        end
        for (int i = 0; i < N_MEM; i++) begin
            load_word(stored_q[i]);
        end
        wait_drain();
    endtask

    task automatic stall_writeback();
        logic [31:0] kind;
        saw_full = 1'b0;
        @(negedge clk);
        bp_enable = 1'b1;
        @(posedge clk);
        #1;
        for (int i = 0; i < N_BP; i++) begin
            kind = rand_word() % 4;
            if (kind == 2)
                store_word(rand_word(), rand_word());
            else if (kind == 3)
                load_word(stored_q[rand_word() % stored_q.size()]);
            else
                send(alu_op_e'(rand_word() % 9), mem_none, rand_word(), rand_word(),
                     rand_word(), rand_word(), 1'b1);
        end
        wait_drain();
        @(negedge clk);
        bp_enable = 1'b0;
        @(posedge clk);
        #1;
        wb_ready_i = 1'b1;
        if (!saw_full)
            flag_failure("in_ready_o never fell with both stages full");
    endtask

    task automatic take_branches();
        logic [31:0] r;
        logic [31:0] off;
        r = rand_word();
        off = rand_word() & 32'h0000_0ffc;
        send(alu_beq, mem_none, r, r, off, 4'd1, 1'b1);
        send(alu_beq, mem_none, r, r + 32'd1, off, 4'd2, 1'b1);
        send(alu_bne, mem_none, r, r ^ 32'h10, off, 4'd3, 1'b1);
        send(alu_bne, mem_none, r, r, off, 4'd4, 1'b1);
        send(alu_jal, mem_none, r, r, off, 4'd5, 1'b1);
        wait_drain();
    endtask

    task automatic halt_on_ebreak();
        send(alu_ebreak, mem_none, rand_word(), rand_word(), 32'd0, 4'd7, 1'b1);
        wait_drain();
        @(negedge clk);
        if (!halted_o)
            flag_failure("halted_o low after ebreak retired");
        // a later jump must stall without a record or a redirect
        @(posedge clk);
        #1;
        in_valid_i = 1'b1;
        op_i = alu_jal;
        mem_op_i = mem_none;
        repeat (6) @(posedge clk);
        #1;
        in_valid_i = 1'b0;
        @(negedge clk);
        if (!halted_o)
            flag_failure("halted_o dropped before reset");
        @(posedge clk);
        #1;
    endtask

    task automatic reset_mid_stream();
        reset = 1'b1;
        repeat (2) @(posedge clk);
        exp_q.delete();
        redir_q.delete();
        #1;
        reset = 1'b0;
        @(negedge clk);
        if (wb_valid_o || redirect_o || halted_o)
            flag_failure("wb_valid_o, redirect_o or halted_o high after reset");
        if (!in_ready_o)
            flag_failure("in_ready_o low after reset");
        @(posedge clk);
        #1;
        send(alu_xor, mem_none, rand_word(), rand_word(), 32'd0, 4'd9, 1'b1);
        wait_drain();
    endtask

    initial begin
        reset = 1'b1;
        in_valid_i = 1'b0;
        pc_i = '0;
        op_i = alu_add;
        mem_op_i = mem_none;
        rs1_i = '0;
        rs2_i = '0;
        imm_i = '0;
        rd_i = '0;
        gpr_write_i = 1'b0;
        wb_ready_i = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        #1;
        exercise_alu();
        store_then_load();
        stall_writeback();
        take_branches();
        halt_on_ebreak();
        reset_mid_stream();
        $display("errors: %0d", error_count);
        if (error_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/exe_mem_top.sv
/* execute-to-memory slice; RAM_WORDS must be a power of two from 16 to 4096,
   redirect_o flags a taken branch or jal and the driver discards younger ops */
`default_nettype none

module exe_mem_top #(
    parameter int RAM_WORDS = 256
) (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic                           in_valid_i,
    output logic                                in_ready_o,
    input  wire logic [31:0]                    pc_i,
    input  wire exe_pkg::alu_op_e               op_i,
    input  wire exe_pkg::mem_op_e               mem_op_i,
    input  wire logic [31:0]                    rs1_i,
    input  wire logic [31:0]                    rs2_i,
    input  wire logic [31:0]                    imm_i,
    input  wire logic [exe_pkg::GPR_ADDR_W-1:0] rd_i,
    input  wire logic                           gpr_write_i,
    output logic                                wb_valid_o,
    input  wire logic                           wb_ready_i,
    output logic [31:0]                         wb_pc_o,
    output logic [exe_pkg::GPR_ADDR_W-1:0]      wb_rd_o,
    output logic                                wb_write_o,
    output logic [31:0]                         wb_data_o,
    output logic                                redirect_o,
    output logic [31:0]                         redirect_pc_o,
    output logic                                halted_o
);

    import exe_pkg::*;

    localparam int ADDR_W = $clog2(RAM_WORDS);

    logic [ADDR_W-1:0] ram_addr;
    logic              ram_we;
    logic [BE_W-1:0]   ram_be;
    logic [XLEN-1:0]   ram_wdata;
    logic [XLEN-1:0]   ram_rdata;

    exe_mem_if exe_in ();
    exe_mem_if exe_mem ();

    exe_unit exe_unit_i (
        .pc_i        (pc_i),
        .op_i        (op_i),
        .mem_op_i    (mem_op_i),
        .rs1_i       (rs1_i),
        .rs2_i       (rs2_i),
        .imm_i       (imm_i),
        .rd_i        (rd_i),
        .gpr_write_i (gpr_write_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .out_o       (exe_in.producer)
    );

    exe_mem_reg exe_mem_reg_i (
        .clk           (clk),
        .reset         (reset),
        .in_i          (exe_in.consumer),
        .out_o         (exe_mem.producer),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    mem_unit #(
        .RAM_WORDS (RAM_WORDS)
    ) mem_unit_i (
        .clk         (clk),
        .reset       (reset),
        .in_i        (exe_mem.consumer),
        .ram_addr_o  (ram_addr),
        .ram_we_o    (ram_we),
        .ram_be_o    (ram_be),
        .ram_wdata_o (ram_wdata),
        .ram_rdata_i (ram_rdata),
        .wb_valid_o  (wb_valid_o),
        .wb_ready_i  (wb_ready_i),
        .wb_pc_o     (wb_pc_o),
        .wb_rd_o     (wb_rd_o),
        .wb_write_o  (wb_write_o),
        .wb_data_o   (wb_data_o),
        .halted_o    (halted_o)
    );

    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) data_ram_i (
        .clk     (clk),
        .addr_i  (ram_addr),
        .we_i    (ram_we),
        .be_i    (ram_be),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

endmodule

`default_nettype wire

//--- source/data_ram.sv
/* single-port word RAM, read data one cycle after the address; a write
   returns the old word on that cycle; contents are not reset */
`default_nettype none

module data_ram #(
    parameter int RAM_WORDS = 256,
    localparam int ADDR_W   = $clog2(RAM_WORDS)
) (
    input  wire logic                     clk,
    input  wire logic [ADDR_W-1:0]        addr_i,
    input  wire logic                     we_i,
    input  wire logic [exe_pkg::BE_W-1:0] be_i,
    input  wire logic [31:0]              wdata_i,
    output logic [31:0]                   rdata_o
);

    import exe_pkg::*;

    logic [XLEN-1:0] mem [RAM_WORDS];

    always_ff @(posedge clk) begin
        for (int i = 0; i < BE_W; i++) begin
            if (we_i && be_i[i]) begin
                mem[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
            end
        end
        rdata_o <= mem[addr_i];
    end

endmodule

`default_nettype wire

//--- source/mem_unit.sv
/* memory stage with a one-entry writeback record; word loads only, address
   bits [1:0] are ignored; after ebreak it accepts nothing until reset */
`default_nettype none

module mem_unit #(
    parameter int RAM_WORDS = 256,
    localparam int ADDR_W   = $clog2(RAM_WORDS)
) (
    input  wire logic                           clk,
    input  wire logic                           reset,
    exe_mem_if.consumer                         in_i,
    output logic [ADDR_W-1:0]                   ram_addr_o,
    output logic                                ram_we_o,
    output logic [exe_pkg::BE_W-1:0]            ram_be_o,
    output logic [31:0]                         ram_wdata_o,
    input  wire logic [31:0]                    ram_rdata_i,
    output logic                                wb_valid_o,
    input  wire logic                           wb_ready_i,
    output logic [31:0]                         wb_pc_o,
    output logic [exe_pkg::GPR_ADDR_W-1:0]      wb_rd_o,
    output logic                                wb_write_o,
    output logic [31:0]                         wb_data_o,
    output logic                                halted_o
);

    import exe_pkg::*;

    logic                  accept;
    logic [ADDR_W-1:0]     new_addr;
    logic [ADDR_W-1:0]     addr_q;
    logic                  halted_q;
    logic                  wb_valid_q;
    logic [XLEN-1:0]       wb_pc_q;
    logic [GPR_ADDR_W-1:0] wb_rd_q;
    logic                  wb_write_q;
    logic [XLEN-1:0]       wb_result_q;
    logic                  wb_load_q;

    assign in_i.ready = !halted_q && (!wb_valid_q || wb_ready_i);
    assign accept     = in_i.valid && in_i.ready;
    assign new_addr   = in_i.alu_result[ADDR_W+1:2];

    // while the record waits, keep re-reading its address so load data holds
    assign ram_addr_o  = in_i.ready ? new_addr : addr_q;
    assign ram_we_o    = accept && (in_i.mem_op == mem_store);
    assign ram_be_o    = in_i.byte_mask;
    assign ram_wdata_o = in_i.store_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid_q <= 1'b0;
            halted_q   <= 1'b0;
        end else begin
            if (accept) begin
                wb_valid_q <= 1'b1;
            end else if (wb_ready_i) begin
                wb_valid_q <= 1'b0;
            end
            // sticky
            if (accept && in_i.is_break) begin
                halted_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q      <= new_addr;
            wb_pc_q     <= in_i.pc;
            wb_rd_q     <= in_i.rd;
            wb_write_q  <= in_i.gpr_write;
            wb_result_q <= in_i.alu_result;
            wb_load_q   <= (in_i.mem_op == mem_load);
        end
    end

    assign wb_valid_o = wb_valid_q;
    assign wb_pc_o    = wb_pc_q;
    assign wb_rd_o    = wb_rd_q;
    assign wb_write_o = wb_write_q;
    assign wb_data_o  = wb_load_q ? ram_rdata_i : wb_result_q;
    assign halted_o   = halted_q;

endmodule

`default_nettype wire

//--- source/exe_mem_reg.sv
/* single-entry execute/memory register; it takes no input in the cycle it
   hands a redirecting bundle onward, younger ops are dropped upstream */
`default_nettype none

module exe_mem_reg (
    input  wire logic   clk,
    input  wire logic   reset,
    exe_mem_if.consumer in_i,
    exe_mem_if.producer out_o,
    output logic        redirect_o,
    output logic [31:0] redirect_pc_o
);

    import exe_pkg::*;

    logic                  valid_q;
    logic [XLEN-1:0]       pc_q;
    logic [XLEN-1:0]       npc_q;
    logic                  redirect_q;
    logic [XLEN-1:0]       alu_result_q;
    logic [XLEN-1:0]       store_data_q;
    logic [BE_W-1:0]       byte_mask_q;
    mem_op_e               mem_op_q;
    logic [GPR_ADDR_W-1:0] rd_q;
    logic                  gpr_write_q;
    logic                  is_break_q;
    logic                  flush;

    // redirecting bundle leaves this cycle
    assign flush = valid_q && redirect_q && out_o.ready;

    // slides when the downstream stage takes the held bundle
    assign in_i.ready = !flush && (!valid_q || out_o.ready);

    assign redirect_o    = flush;
    assign redirect_pc_o = flush ? npc_q : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else if (in_i.ready) begin
            valid_q <= in_i.valid;
        end
    end

    // payload only moves on an accepted transfer
    always_ff @(posedge clk) begin
        if (in_i.valid && in_i.ready) begin
            pc_q         <= in_i.pc;
            npc_q        <= in_i.npc;
            redirect_q   <= in_i.redirect;
            alu_result_q <= in_i.alu_result;
            store_data_q <= in_i.store_data;
            byte_mask_q  <= in_i.byte_mask;
            mem_op_q     <= in_i.mem_op;
            rd_q         <= in_i.rd;
            gpr_write_q  <= in_i.gpr_write;
            is_break_q   <= in_i.is_break;
        end
    end

    assign out_o.valid      = valid_q;
    assign out_o.pc         = pc_q;
    assign out_o.npc        = npc_q;
    assign out_o.redirect   = redirect_q;
    assign out_o.alu_result = alu_result_q;
    assign out_o.store_data = store_data_q;
    assign out_o.byte_mask  = byte_mask_q;
    assign out_o.mem_op     = mem_op_q;
    assign out_o.rd         = rd_q;
    assign out_o.gpr_write  = gpr_write_q;
    assign out_o.is_break   = is_break_q;

endmodule

`default_nettype wire

//--- source/exe_unit.sv
/* combinational execute stage; operands arrive already read, and a memory op
   always computes rs1 + imm as its address whatever op_i selects */
`default_nettype none

module exe_unit (
    input  wire logic [31:0]                    pc_i,
    input  wire exe_pkg::alu_op_e               op_i,
    input  wire exe_pkg::mem_op_e               mem_op_i,
    input  wire logic [31:0]                    rs1_i,
    input  wire logic [31:0]                    rs2_i,
    input  wire logic [31:0]                    imm_i,
    input  wire logic [exe_pkg::GPR_ADDR_W-1:0] rd_i,
    input  wire logic                           gpr_write_i,
    input  wire logic                           in_valid_i,
    output logic                                in_ready_o,
    exe_mem_if.producer                         out_o
);

    import exe_pkg::*;

    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] pc_plus_imm;
    logic            operands_eq;
    logic            is_branch;
    logic            is_store;
    logic            is_break;
    logic            taken;

    assign pc_plus4    = pc_i + 32'd4;
    assign pc_plus_imm = pc_i + imm_i;
    assign operands_eq = (rs1_i == rs2_i);
    assign is_branch   = (op_i == alu_beq) || (op_i == alu_bne);
    assign is_store    = (mem_op_i == mem_store);
    assign is_break    = (op_i == alu_ebreak);

    always_comb begin
        case (op_i)
            alu_add: alu_result = rs1_i + rs2_i;
            alu_sub: alu_result = rs1_i - rs2_i;
            alu_and: alu_result = rs1_i & rs2_i;
            alu_or:  alu_result = rs1_i | rs2_i;
            alu_xor: alu_result = rs1_i ^ rs2_i;
            alu_sll: alu_result = rs1_i << rs2_i[4:0];
            alu_srl: alu_result = rs1_i >> rs2_i[4:0];
            alu_slt: alu_result = {31'd0, $signed(rs1_i) < $signed(rs2_i)};
            alu_imm: alu_result = imm_i;
            // link address
            alu_jal: alu_result = pc_plus4;
            default: alu_result = '0;
        endcase
        if (mem_op_i != mem_none) begin
            alu_result = rs1_i + imm_i;
        end
    end

    always_comb begin
        case (op_i)
            alu_beq: taken = operands_eq;
            alu_bne: taken = !operands_eq;
            alu_jal: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // purely combinational, so the handshake passes straight through
    assign out_o.valid = in_valid_i;
    assign in_ready_o  = out_o.ready;

    assign out_o.pc         = pc_i;
    assign out_o.npc        = taken ? pc_plus_imm : pc_plus4;
    assign out_o.redirect   = taken;
    assign out_o.alu_result = alu_result;
    assign out_o.store_data = rs2_i;
    assign out_o.byte_mask  = is_store ? {BE_W{1'b1}} : '0;
    assign out_o.mem_op     = mem_op_i;
    assign out_o.rd         = rd_i;
    // stores, branches and ebreak never write a register
    assign out_o.gpr_write  = gpr_write_i && !is_store && !is_branch && !is_break;
    assign out_o.is_break   = is_break;

endmodule

`default_nettype wire

//--- source/exe_mem_if.sv
/* one execute/memory bundle with valid/ready; the producer holds all fields
   steady while valid is high and ready is low */
`default_nettype none

interface exe_mem_if;

    import exe_pkg::*;

    logic                  valid;
    logic                  ready;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       npc;
    logic                  redirect;
    // doubles as the memory address
    logic [XLEN-1:0]       alu_result;
    logic [XLEN-1:0]       store_data;
    logic [BE_W-1:0]       byte_mask;
    mem_op_e               mem_op;
    logic [GPR_ADDR_W-1:0] rd;
    logic                  gpr_write;
    logic                  is_break;

    modport producer (
        output valid,
        input  ready,
        output pc,
        output npc,
        output redirect,
        output alu_result,
        output store_data,
        output byte_mask,
        output mem_op,
        output rd,
        output gpr_write,
        output is_break
    );

    modport consumer (
        input  valid,
        output ready,
        input  pc,
        input  npc,
        input  redirect,
        input  alu_result,
        input  store_data,
        input  byte_mask,
        input  mem_op,
        input  rd,
        input  gpr_write,
        input  is_break
    );

endinterface

`default_nettype wire

//--- source/exe_pkg.sv
/* shared encodings for the execute/memory slice; data path is fixed at 32 bits
   and only word loads and full-word stores are encoded */
`default_nettype none

package exe_pkg;

    // word and byte lane widths of the bundle
    localparam int XLEN = 32;
    localparam int BE_W = XLEN / 8;

    // sixteen integer registers (RV32E)
    localparam int GPR_ADDR_W = 4;

    // second ALU operand is rs2 except for alu_imm, which passes the immediate
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_sll    = 4'd5,
        alu_srl    = 4'd6,
        alu_slt    = 4'd7,
        alu_imm    = 4'd8,
        alu_beq    = 4'd9,
        alu_bne    = 4'd10,
        alu_jal    = 4'd11,
        alu_ebreak = 4'd12
    } alu_op_e;

    // a memory op overrides the ALU result with rs1 + imm as address
    typedef enum logic [1:0] {
        mem_none  = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_op_e;

endpackage

`default_nettype wire
